// File: hw/dacSys_consts.svh
// Word-addressed map; each region is 4 words and only ADDR_W, DATA_W widths of 11 and 16 are tested
`ifndef DACSYS_CONSTS_SVH
`define DACSYS_CONSTS_SVH

// ******************************
// Host bus
// ******************************
`define ADDR_W 11
`define DATA_W 16
// Returned by MISC VERSION
`define VERSION_WORD 16'h0A31

// Region bases, upper address bits select the block
`define MISC_BASE    11'h000
`define GPIO_BASE    11'h004
`define SERIAL_BASE  11'h008
`define INTERP0_BASE 11'h00C
`define INTERP1_BASE 11'h010
`define INTERP2_BASE 11'h014

// Word offsets inside a region
`define RESET_OFS   2'd0
`define VERSION_OFS 2'd1
`define CMD_OFS     2'd0
`define WDATA_OFS   2'd1
`define STATUS_OFS  2'd2
`define RATIO_OFS   2'd0
`define OFFSET_OFS  2'd1

// Both lock lines inactive high
`define GPIO_INIT 16'h0003

// ******************************
// Serial port and DAC datapath
// ******************************
// Clocks per serial bit, must be even
`define SCLK_DIV 4
// Command byte then data byte
`define FRAME_BITS 16
// Busy flag position in STATUS
`define STATUS_BUSY_BIT 8
`define SAMPLE_W 18
`define DAC_W 14
// Offset-binary zero
`define DAC_MID 14'h2000

`endif

// File: hw/hostBusPkg.sv
// Host bus types only; widths follow ADDR_W and DATA_W from the consts header
`include "dacSys_consts.svh"

package hostBusPkg;

  // One bus word address
  typedef logic [`ADDR_W-1:0] addrT;
  // One bus data word
  typedef logic [`DATA_W-1:0] dataT;
  // Word offset inside a region, the low address bits
  typedef logic [1:0] offsetT;

  // Decoded register block
  // NONE covers every unmapped address
  typedef enum logic [2:0] {
    MISC,
    GPIO,
    SERIAL,
    INTERP0,
    INTERP1,
    INTERP2,
    NONE
  } regionT;

  // Serial command byte, first on the wire
  // DAC index 3 selects no chip
  typedef struct packed {
    logic       rd;
    logic [1:0] dacIdx;
    logic [4:0] regAddr;
  } serialCmdT;

endpackage

// File: hw/dspPkg.sv
// Sample and DAC word types; samples are two's complement, DAC codes offset binary
`include "dacSys_consts.svh"

package dspPkg;

  // Demodulator output sample
  typedef logic signed [`SAMPLE_W-1:0] sampleT;

  // Parallel DAC bus code
  // Midscale sits at DAC_MID
  typedef logic [`DAC_W-1:0] dacWordT;

  // log2 of clocks per input sample
  // 0 to 3 gives 1, 2, 4 or 8
  typedef logic [1:0] ratioT;

endpackage

// File: hw/hostRegs.sv
// Bus is synchronous to ck933; write strobes are combinational, rdData holds until the next read
`timescale 1ns/100ps
`include "dacSys_consts.svh"

module hostRegs (
  input  logic               ck933,
  input  logic               rstN,
  input  logic               nCs,
  input  logic               nWe,
  input  logic               nRd,
  input  hostBusPkg::addrT   addr,
  input  hostBusPkg::dataT   wrData,
  output hostBusPkg::dataT   rdData,
  input  hostBusPkg::dataT   serialRd,
  input  hostBusPkg::dataT   interpRd0,
  input  hostBusPkg::dataT   interpRd1,
  input  hostBusPkg::dataT   interpRd2,
  output logic               serialWrEn,
  output logic               interpWrEn0,
  output logic               interpWrEn1,
  output logic               interpWrEn2,
  output hostBusPkg::offsetT wrOffset,
  output logic               softReset,
  output hostBusPkg::dataT   gpioOut
);

  hostBusPkg::regionT region;
  hostBusPkg::dataT   rdMux;
  logic               wrStrobe;
  logic               rdStrobe;

  // ******************************
  // Address decode
  // ******************************
  // Region from the upper bits
  // Bases are 4-word aligned
  always_comb begin
    case (addr[`ADDR_W-1:2])
      (`MISC_BASE >> 2):    region = hostBusPkg::MISC;
      (`GPIO_BASE >> 2):    region = hostBusPkg::GPIO;
      (`SERIAL_BASE >> 2):  region = hostBusPkg::SERIAL;
      (`INTERP0_BASE >> 2): region = hostBusPkg::INTERP0;
      (`INTERP1_BASE >> 2): region = hostBusPkg::INTERP1;
      (`INTERP2_BASE >> 2): region = hostBusPkg::INTERP2;
      default:              region = hostBusPkg::NONE;
    endcase
  end

  // Offset shared by every block
  // Also selects the block read word
  assign wrOffset = addr[1:0];

  // Active-low strobes, qualified by chip select
  assign wrStrobe = !nCs && !nWe;
  assign rdStrobe = !nCs && !nRd;

  // Per-region write pulses, one cycle per bus write
  assign serialWrEn  = wrStrobe && (region == hostBusPkg::SERIAL);
  assign interpWrEn0 = wrStrobe && (region == hostBusPkg::INTERP0);
  assign interpWrEn1 = wrStrobe && (region == hostBusPkg::INTERP1);
  assign interpWrEn2 = wrStrobe && (region == hostBusPkg::INTERP2);

  // ******************************
  // Misc and GPIO registers
  // ******************************
  // Soft reset pulse
  // Cleared only by the pin reset so it self-terminates
  always_ff @(posedge ck933) begin
    if (!rstN) begin
      softReset <= 1'b0;
    end else begin
      softReset <= wrStrobe && (region == hostBusPkg::MISC) && (wrOffset == `RESET_OFS);
    end
  end

  // GPIO word
  // Bit 0 bit sync lock, bit 1 demod lock, both active low
  always_ff @(posedge ck933) begin
    if (!rstN || softReset) begin
      gpioOut <= `GPIO_INIT;
    end else if (wrStrobe && (region == hostBusPkg::GPIO)) begin
      gpioOut <= wrData;
    end
  end

  // ******************************
  // Read data mux
  // ******************************
  always_comb begin
    rdMux = '0;
    case (region)
      hostBusPkg::MISC: begin
        // RESET reads back as zero
        if (wrOffset == `VERSION_OFS) begin
          rdMux = `VERSION_WORD;
        end
      end
      hostBusPkg::GPIO:    rdMux = gpioOut;
      hostBusPkg::SERIAL:  rdMux = serialRd;
      hostBusPkg::INTERP0: rdMux = interpRd0;
      hostBusPkg::INTERP1: rdMux = interpRd1;
      hostBusPkg::INTERP2: rdMux = interpRd2;
      // Unmapped reads return zero
      default:             rdMux = '0;
    endcase
  end

  // Captured on the read edge
  // Held until the next read
  always_ff @(posedge ck933) begin
    if (rdStrobe) begin
      rdData <= rdMux;
    end
  end

endmodule

// File: hw/dacSerialCtrl.sv
// Three-wire DAC port master; sclk is a registered enable-rate clock, WDATA writes while busy drop
`timescale 1ns/100ps
`include "dacSys_consts.svh"

module dacSerialCtrl (
  input  logic               ck933,
  input  logic               rstN,
  input  logic               softReset,
  input  logic               wrEn,
  input  hostBusPkg::offsetT wrOffset,
  input  hostBusPkg::dataT   wrData,
  output hostBusPkg::dataT   rdData,
  output logic               sclk,
  output logic [2:0]         dacNCs,
  output logic               sdioOut,
  output logic               sdioOe,
  input  logic               sdioIn
);

  localparam int phaseW  = $clog2(`SCLK_DIV);
  localparam int bitW    = $clog2(`FRAME_BITS);
  localparam int halfDiv = `SCLK_DIV / 2;

  typedef enum logic [1:0] {
    sIdle,
    sLoad,
    sShift,
    sEnd
  } stateT;

  stateT                  state;
  hostBusPkg::serialCmdT  cmd;
  logic [7:0]             txByte;
  logic [7:0]             rxByte;
  logic [`FRAME_BITS-1:0] shiftReg;
  logic [bitW-1:0]        bitCnt;
  logic [phaseW-1:0]      phase;
  logic [3:0]             selOneHot;
  logic                   busy;
  logic                   startFrame;

  assign busy = (state != sIdle);
  // A WDATA write starts a frame only when idle
  assign startFrame = wrEn && (wrOffset == `WDATA_OFS) && !busy;
  // Index 3 falls off the top, no chip selected
  assign selOneHot = 4'b0001 << cmd.dacIdx;

  // ******************************
  // Frame sequencer
  // ******************************
  always_ff @(posedge ck933) begin
    if (!rstN || softReset) begin
      state    <= sIdle;
      cmd      <= '0;
      txByte   <= '0;
      rxByte   <= '0;
      shiftReg <= '0;
      bitCnt   <= '0;
      phase    <= '0;
      sclk     <= 1'b0;
      dacNCs   <= 3'b111;
      sdioOut  <= 1'b0;
      sdioOe   <= 1'b0;
    end else begin
      case (state)
        sIdle: begin
          // Command only changes between frames
          if (wrEn && (wrOffset == `CMD_OFS)) begin
            cmd <= wrData[7:0];
          end
          if (startFrame) begin
            txByte <= wrData[7:0];
            state  <= sLoad;
          end
        end
        sLoad: begin
          // Chip select drops, first bit on the line
          shiftReg <= {cmd, txByte};
          sdioOut  <= cmd[7];
          sdioOe   <= 1'b1;
          dacNCs   <= ~selOneHot[2:0];
          bitCnt   <= '0;
          phase    <= '0;
          state    <= sShift;
        end
        sShift: begin
          phase <= phase + 1'b1;
          // Rising half of the bit
          // Held low when no chip is selected
          if (phase == phaseW'(halfDiv - 1)) begin
            sclk <= ~&dacNCs;
          end
          // Read byte sampled with sclk high
          if (cmd.rd && (bitCnt >= bitW'(8)) && (phase == phaseW'(halfDiv))) begin
            rxByte <= {rxByte[6:0], sdioIn};
          end
          // Falling edge, next bit or end of frame
          if (phase == phaseW'(`SCLK_DIV - 1)) begin
            sclk  <= 1'b0;
            phase <= '0;
            if (bitCnt == bitW'(`FRAME_BITS - 1)) begin
              dacNCs <= 3'b111;
              sdioOe <= 1'b0;
              state  <= sEnd;
            end else begin
              bitCnt   <= bitCnt + 1'b1;
              shiftReg <= shiftReg << 1;
              sdioOut  <= shiftReg[`FRAME_BITS-2];
              // Turnaround after the command byte
              if (cmd.rd && (bitCnt == bitW'(7))) begin
                sdioOe <= 1'b0;
              end
            end
          end
        end
        sEnd: begin
          // Two idle clocks with chip select high
          phase <= phase + 1'b1;
          if (phase == phaseW'(1)) begin
            state <= sIdle;
          end
        end
        default: state <= sIdle;
      endcase
    end
  end

  // ******************************
  // Register read back
  // ******************************
  always_comb begin
    rdData = '0;
    case (wrOffset)
      `CMD_OFS:   rdData[7:0] = cmd;
      `WDATA_OFS: rdData[7:0] = txByte;
      `STATUS_OFS: begin
        rdData[7:0]              = rxByte;
        rdData[`STATUS_BUSY_BIT] = busy;
      end
      default: rdData = '0;
    endcase
  end

endmodule

// File: hw/interpolator.sv
// Linear interpolator; the source strobes every 2^ratio clocks and OFFSET is in sample LSBs
`timescale 1ns/100ps
`include "dacSys_consts.svh"

module interpolator (
  input  logic               ck933,
  input  logic               rstN,
  input  logic               softReset,
  input  logic               wrEn,
  input  hostBusPkg::offsetT wrOffset,
  input  hostBusPkg::dataT   wrData,
  output hostBusPkg::dataT   rdData,
  input  dspPkg::sampleT     sample,
  input  logic               sampleEn,
  output dspPkg::dacWordT    dacWord
);

  // Three fraction bits make every step exact up to ratio 3
  localparam int fracW = 3;
  localparam int accW  = `SAMPLE_W + fracW + 1;
  localparam int sumW  = accW + 2;
  // Bits dropped to reach the DAC width
  localparam int dropW = `SAMPLE_W - `DAC_W + fracW;
  localparam logic signed [sumW-1:0] roundHalf = 1 <<< (dropW - 1);
  localparam logic signed [sumW-1:0] dacMax = (1 <<< (`DAC_W - 1)) - 1;
  localparam logic signed [sumW-1:0] dacMin = -(1 <<< (`DAC_W - 1));

  dspPkg::ratioT             ratio;
  logic signed [`DATA_W-1:0] offset;
  dspPkg::sampleT            prevSample;
  dspPkg::sampleT            target;
  logic signed [accW-1:0]    acc;
  logic signed [accW-1:0]    step;
  logic [3:0]                stepsLeft;
  logic signed [sumW-1:0]    sum;
  logic signed [sumW-1:0]    rounded;
  logic signed [`DAC_W-1:0]  clipped;

  // ******************************
  // Stepping and output stage
  // ******************************
  // Slope per clock, difference scaled by 2^-ratio
  assign step = ((accW'(target) - accW'(prevSample)) <<< fracW) >>> ratio;

  // Offset added at the fraction scale
  assign sum     = sumW'(acc) + (sumW'(offset) <<< fracW);
  assign rounded = (sum + roundHalf) >>> dropW;

  // Saturate to signed DAC range
  always_comb begin
    if (rounded > dacMax) begin
      clipped = dacMax[`DAC_W-1:0];
    end else if (rounded < dacMin) begin
      clipped = dacMin[`DAC_W-1:0];
    end else begin
      clipped = rounded[`DAC_W-1:0];
    end
  end

  always_ff @(posedge ck933) begin
    if (!rstN || softReset) begin
      ratio      <= '0;
      offset     <= '0;
      prevSample <= '0;
      target     <= '0;
      acc        <= '0;
      stepsLeft  <= '0;
      dacWord    <= `DAC_MID;
    end else begin
      if (wrEn && (wrOffset == `RATIO_OFS)) begin
        ratio <= wrData[1:0];
      end
      if (wrEn && (wrOffset == `OFFSET_OFS)) begin
        offset <= wrData;
      end
      // New sample, restart the ramp from the old target
      if (sampleEn) begin
        prevSample <= target;
        target     <= sample;
        acc        <= accW'(target) <<< fracW;
        stepsLeft  <= 4'd1 << ratio;
      end else if (stepsLeft != 4'd0) begin
        // Ramp stops on the target if strobes run late
        acc       <= acc + step;
        stepsLeft <= stepsLeft - 1'b1;
      end
      // Sign bit flipped for offset binary
      dacWord <= {~clipped[`DAC_W-1], clipped[`DAC_W-2:0]};
    end
  end

  // Host read back
  always_comb begin
    rdData = '0;
    case (wrOffset)
      `RATIO_OFS:  rdData[1:0] = ratio;
      `OFFSET_OFS: rdData = offset;
      default:     rdData = '0;
    endcase
  end

endmodule

// File: hw/dacSubsystem.sv
// DAC subsystem top; the sdio pad and DAC clocking sit outside, all ports synchronous to ck933
`timescale 1ns/100ps

module dacSubsystem (
  input  logic             ck933,
  input  logic             rstN,
  // Host bus
  input  logic             nCs,
  input  logic             nWe,
  input  logic             nRd,
  input  hostBusPkg::addrT addr,
  input  hostBusPkg::dataT wrData,
  output hostBusPkg::dataT rdData,
  // Demodulator sample streams
  input  dspPkg::sampleT   sample0,
  input  dspPkg::sampleT   sample1,
  input  dspPkg::sampleT   sample2,
  input  logic             sampleEn0,
  input  logic             sampleEn1,
  input  logic             sampleEn2,
  // Shared DAC serial port
  output logic             sclk,
  output logic             dacNCs0,
  output logic             dacNCs1,
  output logic             dacNCs2,
  output logic             sdioOut,
  output logic             sdioOe,
  input  logic             sdioIn,
  // Parallel DAC buses
  output dspPkg::dacWordT  dacWord0,
  output dspPkg::dacWordT  dacWord1,
  output dspPkg::dacWordT  dacWord2,
  output logic             dacRst,
  // Lock indicators, active low
  output logic             bsyncNLock,
  output logic             demodNLock
);

  hostBusPkg::offsetT wrOffset;
  hostBusPkg::dataT   serialRd;
  hostBusPkg::dataT   interpRd0;
  hostBusPkg::dataT   interpRd1;
  hostBusPkg::dataT   interpRd2;
  hostBusPkg::dataT   gpioOut;
  logic               serialWrEn;
  logic               interpWrEn0;
  logic               interpWrEn1;
  logic               interpWrEn2;
  logic               softReset;
  logic [2:0]         dacNCs;

  // ******************************
  // Host registers and decode
  // ******************************
  hostRegs hostRegs (
    .ck933       (ck933),
    .rstN        (rstN),
    .nCs         (nCs),
    .nWe         (nWe),
    .nRd         (nRd),
    .addr        (addr),
    .wrData      (wrData),
    .rdData      (rdData),
    .serialRd    (serialRd),
    .interpRd0   (interpRd0),
    .interpRd1   (interpRd1),
    .interpRd2   (interpRd2),
    .serialWrEn  (serialWrEn),
    .interpWrEn0 (interpWrEn0),
    .interpWrEn1 (interpWrEn1),
    .interpWrEn2 (interpWrEn2),
    .wrOffset    (wrOffset),
    .softReset   (softReset),
    .gpioOut     (gpioOut)
  );

  // Soft reset pulse doubles as the DAC reset pin
  assign dacRst     = softReset;
  assign bsyncNLock = gpioOut[0];
  assign demodNLock = gpioOut[1];

  // ******************************
  // Serial configuration port
  // ******************************
  dacSerialCtrl dacSerialCtrl (
    .ck933     (ck933),
    .rstN      (rstN),
    .softReset (softReset),
    .wrEn      (serialWrEn),
    .wrOffset  (wrOffset),
    .wrData    (wrData),
    .rdData    (serialRd),
    .sclk      (sclk),
    .dacNCs    (dacNCs),
    .sdioOut   (sdioOut),
    .sdioOe    (sdioOe),
    .sdioIn    (sdioIn)
  );

  assign dacNCs0 = dacNCs[0];
  assign dacNCs1 = dacNCs[1];
  assign dacNCs2 = dacNCs[2];

  // ******************************
  // Interpolators, one per DAC
  // ******************************
  interpolator interp0 (
    .ck933     (ck933),
    .rstN      (rstN),
    .softReset (softReset),
    .wrEn      (interpWrEn0),
    .wrOffset  (wrOffset),
    .wrData    (wrData),
    .rdData    (interpRd0),
    .sample    (sample0),
    .sampleEn  (sampleEn0),
    .dacWord   (dacWord0)
  );

  interpolator interp1 (
    .ck933     (ck933),
    .rstN      (rstN),
    .softReset (softReset),
    .wrEn      (interpWrEn1),
    .wrOffset  (wrOffset),
    .wrData    (wrData),
    .rdData    (interpRd1),
    .sample    (sample1),
    .sampleEn  (sampleEn1),
    .dacWord   (dacWord1)
  );

  interpolator interp2 (
    .ck933     (ck933),
    .rstN      (rstN),
    .softReset (softReset),
    .wrEn      (interpWrEn2),
    .wrOffset  (wrOffset),
    .wrData    (wrData),
    .rdData    (interpRd2),
    .sample    (sample2),
    .sampleEn  (sampleEn2),
    .dacWord   (dacWord2)
  );

endmodule

// File: verif/dacSubsystem_asserts.sv
// Protocol assertions for the serial DAC port; checks are off while the pin reset is low
`timescale 1ns/100ps

module dacSubsystem_asserts (
  input logic       ck933,
  input logic       rstN,
  input logic       sclk,
  input logic [2:0] dacNCs,
  input logic       sdioOe,
  input logic       busy
);

  // Failures seen, read by the testbench at the end of the run
  int failCount;

  initial failCount = 0;

  // ******************************
  // Serial port protocol
  // ******************************
  // The last sclk fall shares its edge with chip select rising
  sclkInFrame: assert property (@(posedge ck933) disable iff (!rstN)
    $changed(sclk) |-> !(&$past(dacNCs)))
    else begin
      failCount++;
      $error("sclk toggled with no DAC chip select low");
    end

  oneChipSelect: assert property (@(posedge ck933) disable iff (!rstN)
    $countones(~dacNCs) <= 1)
    else begin
      failCount++;
      $error("more than one DAC chip select low");
    end

  oeIdleLow: assert property (@(posedge ck933) disable iff (!rstN)
    (&dacNCs) |-> !sdioOe)
    else begin
      failCount++;
      $error("sdioOe high with all chip selects high");
    end

  // Busy clears only in the idle tail after the frame
  busyAfterFrame: assert property (@(posedge ck933) disable iff (!rstN)
    $fell(busy) |-> $past(&dacNCs))
    else begin
      failCount++;
      $error("busy fell while a chip select was still low");
    end

endmodule

bind dacSerialCtrl dacSubsystem_asserts serialAsserts (
  .ck933  (ck933),
  .rstN   (rstN),
  .sclk   (sclk),
  .dacNCs (dacNCs),
  .sdioOe (sdioOe),
  .busy   (busy)
);

// File: verif/dacSubsystem_tb.sv
// Self-checking testbench with a serial DAC model; fixed seed, samples kept inside 18-bit range
`timescale 1ns/100ps
`include "dacSys_consts.svh"

module dacSubsystem_tb;

  typedef enum {opWr, opRd, opPort, opSer, opSerRd, opSamp, opMid, opSrst} opT;

  // One table entry, addr holds the channel or DAC index where no address applies
  typedef struct {
    opT op;
    int addr;
    int data;
    int aux;
    int exp;
    int bound;
  } stepT;

  logic                      ck933;
  logic                      rstN;
  logic                      nCs;
  logic                      nWe;
  logic                      nRd;
  hostBusPkg::addrT          addr;
  hostBusPkg::dataT          wrData;
  hostBusPkg::dataT          rdData;
  dspPkg::sampleT            sample [3];
  logic [2:0]                sampleEn;
  logic                      sclk;
  logic [2:0]                dacNCs;
  logic                      sdioOut;
  logic                      sdioOe;
  logic                      sdioIn;
  dspPkg::dacWordT           dacWord [3];
  logic                      dacRst;
  logic                      bsyncNLock;
  logic                      demodNLock;

  stepT                      steps [$];
  int                        errCount;
  int                        checkCount;
  int                        totalErr;
  int                        interpBase [3];

  // Serial DAC model state
  logic                      csIdle;
  logic [15:0]               capWord;
  int                        capBits;
  logic [2:0]                capCs;
  logic [7:0]                modelRet;
  hostBusPkg::serialCmdT     cmdSeen;

  dacSubsystem DUT (
    .ck933      (ck933),
    .rstN       (rstN),
    .nCs        (nCs),
    .nWe        (nWe),
    .nRd        (nRd),
    .addr       (addr),
    .wrData     (wrData),
    .rdData     (rdData),
    .sample0    (sample[0]),
    .sample1    (sample[1]),
    .sample2    (sample[2]),
    .sampleEn0  (sampleEn[0]),
    .sampleEn1  (sampleEn[1]),
    .sampleEn2  (sampleEn[2]),
    .sclk       (sclk),
    .dacNCs0    (dacNCs[0]),
    .dacNCs1    (dacNCs[1]),
    .dacNCs2    (dacNCs[2]),
    .sdioOut    (sdioOut),
    .sdioOe     (sdioOe),
    .sdioIn     (sdioIn),
    .dacWord0   (dacWord[0]),
    .dacWord1   (dacWord[1]),
    .dacWord2   (dacWord[2]),
    .dacRst     (dacRst),
    .bsyncNLock (bsyncNLock),
    .demodNLock (demodNLock)
  );

  initial begin
    ck933 = 1'b0;
    forever #20 ck933 = ~ck933;
  end

  // ******************************
  // Checks and bus access
  // ******************************
  task automatic compareValue(input logic [31:0] got, input logic [31:0] exp, input string what);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("[FAIL] %0t ns: %s, got 0x%0h expected 0x%0h", $time, what, got, exp);
    end
  endtask

  // Write lands on the rising edge inside the strobe
  task automatic busWrite(input int a, input int d);
    @(negedge ck933);
    nCs = 1'b0;
    nWe = 1'b0;
    addr = a[`ADDR_W-1:0];
    wrData = d[`DATA_W-1:0];
    @(negedge ck933);
    nCs = 1'b1;
    nWe = 1'b1;
  endtask

  // rdData is stable by the falling edge after the strobe
  task automatic busRead(input int a, output logic [`DATA_W-1:0] d);
    @(negedge ck933);
    nCs = 1'b0;
    nRd = 1'b0;
    addr = a[`ADDR_W-1:0];
    @(negedge ck933);
    nCs = 1'b1;
    nRd = 1'b1;
    d = rdData;
  endtask

  // Sum rounded to 1/16 sample, clamped, then offset binary
  function automatic int dacCode(input int s, input int off);
    int q;
    int full;
    full = 1 << (`DAC_W - 1);
    q = (s + off + 8) >>> 4;
    if (q > full - 1) q = full - 1;
    if (q < -full) q = -full;
    return q + full;
  endfunction

  // ******************************
  // Serial DAC model
  // ******************************
  assign csIdle = &dacNCs;

  always @(negedge csIdle) begin
    capWord = '0;
    capBits = 0;
    capCs = dacNCs;
    cmdSeen = '0;
  end

  always @(posedge sclk) begin
    // Line released only for the read byte
    compareValue(sdioOe, (capBits < 8) || !cmdSeen.rd, "sdioOe during frame");
    capWord = {capWord[14:0], sdioOut};
    capBits = capBits + 1;
    if (capBits == 8) cmdSeen = capWord[7:0];
  end

  // Read byte MSB first, changed well before the controller samples
  always @(negedge sclk) begin
    if (cmdSeen.rd && (capBits >= 8) && (capBits < 16)) begin
      @(negedge ck933);
      sdioIn = modelRet[15 - capBits];
    end
  end

  // ******************************
  // Step execution
  // ******************************
  task automatic runFrame(input stepT s);
    logic [`DATA_W-1:0] st;
    logic [2:0]         csExp;
    csExp = ~(3'b001 << s.addr);
    modelRet = s.aux[7:0];
    busWrite(`SERIAL_BASE + `CMD_OFS, s.data >> 8);
    busWrite(`SERIAL_BASE + `WDATA_OFS, s.data & 'hFF);
    busRead(`SERIAL_BASE + `STATUS_OFS, st);
    compareValue(st[`STATUS_BUSY_BIT], 1'b1, "busy after WDATA write");
    // Poll until the frame and its idle tail are done
    while (st[`STATUS_BUSY_BIT]) begin
      busRead(`SERIAL_BASE + `STATUS_OFS, st);
    end
    compareValue(capBits, 16, "serial frame bit count");
    compareValue(capCs, csExp, "serial chip select");
    if (s.op == opSer) begin
      compareValue(capWord, s.exp, "serial frame word");
    end else begin
      compareValue(capWord[15:8], s.data >> 8, "read command byte");
      compareValue(st, s.exp, "STATUS after serial read");
    end
  endtask

  task automatic sampleStep(input stepT s);
    int half;
    int got;
    half = (1 << s.aux) / 2;
    @(negedge ck933);
    sample[s.addr] = s.data[`SAMPLE_W-1:0];
    sampleEn[s.addr] = 1'b1;
    @(negedge ck933);
    sampleEn[s.addr] = 1'b0;
    if (s.op == opMid) begin
      // Half the ramp done plus the output register
      repeat (half + 1) @(posedge ck933);
      @(negedge ck933);
      got = dacWord[s.addr];
      compareValue((got > s.bound) && (got < s.exp), 1'b1,
                   $sformatf("channel %0d midway word %0d", s.addr, got));
      repeat (half) @(posedge ck933);
    end else begin
      repeat ((1 << s.aux) + 1) @(posedge ck933);
    end
    @(negedge ck933);
    compareValue(dacWord[s.addr], s.exp, $sformatf("channel %0d final word", s.addr));
  endtask

  task automatic applyStep(input stepT s);
    logic [`DATA_W-1:0] rd;
    logic [31:0]        got;
    case (s.op)
      opWr: busWrite(s.addr, s.data);
      opRd: begin
        busRead(s.addr, rd);
        compareValue(rd, s.exp, $sformatf("read at 0x%0h", s.addr));
      end
      opPort: begin
        @(negedge ck933);
        // Port 3 is the lock pair
        if (s.addr == 3) begin
          got = {30'b0, demodNLock, bsyncNLock};
        end else begin
          got = dacWord[s.addr];
        end
        compareValue(got, s.exp, $sformatf("output port %0d", s.addr));
      end
      opSer, opSerRd: runFrame(s);
      opSamp, opMid: sampleStep(s);
      opSrst: begin
        busWrite(`MISC_BASE + `RESET_OFS, 0);
        compareValue(dacRst, 1'b1, "dacRst after RESET write");
        @(negedge ck933);
        compareValue(dacRst, 1'b0, "dacRst one cycle only");
      end
      default: compareValue(0, 1, "unknown table entry");
    endcase
  endtask

  // ******************************
  // Stimulus table
  // ******************************
  task automatic addStep(input opT op, input int a, input int d, input int aux,
                         input int exp, input int bound);
    steps.push_back('{op, a, d, aux, exp, bound});
  endtask

  task automatic buildTable();
    hostBusPkg::serialCmdT c;
    int                    g;
    int                    off;
    int                    v1;
    int                    v2;
    int                    b;
    int                    ratios [3];
    ratios = '{3, 1, 0};
    interpBase = '{`INTERP0_BASE, `INTERP1_BASE, `INTERP2_BASE};
    // Reset values, version, GPIO and unmapped space
    addStep(opPort, 3, 0, 0, 3, 0);
    for (int ch = 0; ch < 3; ch++) addStep(opPort, ch, 0, 0, `DAC_MID, 0);
    addStep(opRd, `MISC_BASE + `VERSION_OFS, 0, 0, `VERSION_WORD, 0);
    addStep(opRd, `GPIO_BASE, 0, 0, `GPIO_INIT, 0);
    g = $urandom & 'hFFFF;
    for (int k = 0; k < 2; k++) begin
      addStep(opWr, `GPIO_BASE, g, 0, 0, 0);
      addStep(opRd, `GPIO_BASE, 0, 0, g, 0);
      addStep(opPort, 3, 0, 0, g & 3, 0);
      g = g ^ 3;
    end
    for (int k = 0; k < 2; k++) addStep(opRd, 'h018 + ($urandom % 2024), 0, 0, 0, 0);
    // Write frames to each DAC, then one read
    for (int idx = 0; idx < 3; idx++) begin
      c = {1'b0, idx[1:0], 5'($urandom)};
      b = $urandom & 'hFF;
      addStep(opSer, idx, {c, b[7:0]}, 0, {c, b[7:0]}, 0);
    end
    c = {1'b1, 2'($urandom % 3), 5'($urandom)};
    b = $urandom & 'hFF;
    addStep(opSerRd, c.dacIdx, {c, 8'($urandom)}, b, b, 0);
    // Interpolation per channel, midway check where the ramp is long enough
    for (int ch = 0; ch < 3; ch++) begin
      off = int'($urandom % 1001) - 500;
      v1 = -1 - int'($urandom % 60000);
      v2 = v1 + 30000 + int'($urandom % 30000);
      addStep(opWr, interpBase[ch] + `RATIO_OFS, ratios[ch], 0, 0, 0);
      addStep(opWr, interpBase[ch] + `OFFSET_OFS, off, 0, 0, 0);
      addStep(opRd, interpBase[ch] + `RATIO_OFS, 0, 0, ratios[ch], 0);
      addStep(opRd, interpBase[ch] + `OFFSET_OFS, 0, 0, off & 'hFFFF, 0);
      addStep(opSamp, ch, v1, ratios[ch], dacCode(v1, off), 0);
      addStep(opSamp, ch, v1, ratios[ch], dacCode(v1, off), 0);
      addStep((ratios[ch] > 0) ? opMid : opSamp, ch, v2, ratios[ch], dacCode(v2, off),
              dacCode(v1, off));
    end
    // Saturation at both ends
    addStep(opWr, `INTERP0_BASE + `OFFSET_OFS, 32767, 0, 0, 0);
    addStep(opSamp, 0, 131071, 3, dacCode(131071, 32767), 0);
    addStep(opWr, `INTERP0_BASE + `OFFSET_OFS, -32768, 0, 0, 0);
    addStep(opSamp, 0, -131072, 3, dacCode(-131072, -32768), 0);
    // Soft reset returns every block to its reset state
    addStep(opSrst, 0, 0, 0, 0, 0);
    addStep(opRd, `GPIO_BASE, 0, 0, `GPIO_INIT, 0);
    addStep(opPort, 3, 0, 0, 3, 0);
    addStep(opRd, `INTERP0_BASE + `RATIO_OFS, 0, 0, 0, 0);
    addStep(opRd, `INTERP0_BASE + `OFFSET_OFS, 0, 0, 0, 0);
    addStep(opRd, `INTERP1_BASE + `RATIO_OFS, 0, 0, 0, 0);
    addStep(opRd, `SERIAL_BASE + `CMD_OFS, 0, 0, 0, 0);
    addStep(opRd, `SERIAL_BASE + `STATUS_OFS, 0, 0, 0, 0);
    for (int ch = 0; ch < 3; ch++) addStep(opPort, ch, 0, 0, `DAC_MID, 0);
    c = {1'b0, 2'd1, 5'($urandom)};
    addStep(opSer, 1, {c, 8'h5A}, 0, {c, 8'h5A}, 0);
  endtask

  // ******************************
  // Main sequence and watchdog
  // ******************************
  initial begin
    void'($urandom(82539));
    errCount = 0;
    checkCount = 0;
    rstN = 1'b0;
    nCs = 1'b1;
    nWe = 1'b1;
    nRd = 1'b1;
    addr = '0;
    wrData = '0;
    sample = '{default: '0};
    sampleEn = '0;
    sdioIn = 1'b0;
    capWord = '0;
    capBits = 0;
    capCs = 3'b111;
    modelRet = '0;
    cmdSeen = '0;
    buildTable();
    repeat (4) @(posedge ck933);
    @(negedge ck933);
    rstN = 1'b1;
    foreach (steps[i]) applyStep(steps[i]);
    repeat (4) @(negedge ck933);
    totalErr = errCount + DUT.dacSerialCtrl.serialAsserts.failCount;
    $display("Run complete: %0d checks, %0d errors", checkCount, totalErr);
    if (totalErr == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #1;
    repeat (steps.size() * 200 + 100) @(posedge ck933);
    $display("Watchdog: the run timed out before all table entries finished");
    $display("Something failed");
    $finish;
  end

endmodule

// File: project.f
+incdir+hw
hw/hostBusPkg.sv
hw/dspPkg.sv
hw/hostRegs.sv
hw/dacSerialCtrl.sv
hw/interpolator.sv
hw/dacSubsystem.sv
verif/dacSubsystem_asserts.sv
verif/dacSubsystem_tb.sv
